/* Bender.yml */
package:
  name: main_board

sources:
  - include_dirs:
      - .
    files:
      - main_pkg.sv
      - main_decoder.sv
      - main_io_regs.sv
      - main_work_ram.sv
      - main_bus_mux.sv
      - main_board.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_main_board.sv

/* main_board.sv */
// ========================================
// Main CPU bus subsystem of the board
// Joins the external CPU bus to the work
// RAM, the I/O registers and the graphics
// and ROM devices outside this block
// ========================================

`timescale 1ns/100ps

`include "main_config.svh"

module main_board (
    input  logic                     clk,
    input  logic                     rst_n,
    // CPU bus
    input  logic [15:0]              cpu_addr,
    input  logic                     cpu_rnw,
    input  logic [ 7:0]              cpu_dout,
    input  logic                     cpu_cen,
    output logic [ 7:0]              cpu_din,
    output logic                     cpu_wait,
    input  logic                     irq_ack,
    output logic                     irq_n,
    // ROM
    output logic                     rom_cs,
    output logic [`MAIN_ROM_AW-1:0]  rom_addr,
    input  logic [ 7:0]              rom_data,
    input  logic                     rom_ok,
    // Video devices
    output logic                     pal_cs,
    output logic                     gfx1_cs,
    output logic                     gfx2_cs,
    input  logic [ 7:0]              pal_dout,
    input  logic [ 7:0]              gfx1_dout,
    input  logic [ 7:0]              gfx2_dout,
    input  logic                     gfx_irqn,
    output logic [ 7:0]              video_bank,
    output logic                     prio_latch,
    // Cabinet
    input  logic [ 1:0]              start_button,
    input  logic [ 1:0]              coin_input,
    input  logic                     service,
    input  logic [ 5:0]              joystick1,
    input  logic [ 5:0]              joystick2,
    // DIP switches
    input  logic                     dip_pause,
    input  logic [ 7:0]              dipsw_a,
    input  logic [ 7:0]              dipsw_b,
    input  logic [ 3:0]              dipsw_c,
    // Sound board
    output logic [ 7:0]              snd_latch,
    output logic                     snd_irq
);

    import main_pkg::*;

    bus_region_e region;
    logic [7:0]  ram_dout;
    logic [7:0]  io_dout;
    logic [3:0]  rom_bank;
    logic        ram_cs;
    logic        io_cs;

    main_decoder u_decoder (.*);

    main_work_ram #(.aw(`MAIN_RAM_AW)) u_ram (
        .clk      ( clk                        ),
        .cpu_cen  ( cpu_cen                    ),
        .cpu_rnw  ( cpu_rnw                    ),
        .ram_cs   ( ram_cs                     ),
        .cpu_addr ( cpu_addr[`MAIN_RAM_AW-1:0] ),
        .cpu_dout ( cpu_dout                   ),
        .ram_dout ( ram_dout                   )
    );

    main_io_regs u_io (.*, .cpu_addr(cpu_addr[4:0]));

    main_bus_mux u_mux (.*);

endmodule

/* main_bus_mux.sv */
// ========================================
// Main CPU read data multiplexer
// Latches the region and any external byte
// on a read strobe, then presents the data
// on cpu_din from the next cycle on
// ========================================

`timescale 1ns/100ps

module main_bus_mux (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cpu_cen,
    input  logic                  cpu_rnw,
    input  main_pkg::bus_region_e region,
    input  logic [7:0]            ram_dout,
    input  logic [7:0]            io_dout,
    input  logic [7:0]            rom_data,
    input  logic [7:0]            pal_dout,
    input  logic [7:0]            gfx1_dout,
    input  logic [7:0]            gfx2_dout,
    output logic [7:0]            cpu_din
);

    import main_pkg::*;

    bus_region_e rd_region;
    logic [7:0]  ext_dout;
    logic [7:0]  ext_sel;
    logic        rd_stb;

    assign rd_stb = cpu_cen & cpu_rnw;

    // External devices only hold their data during the strobe
    always_comb begin
        case (region)
            REGION_ROM:  ext_sel = rom_data;
            REGION_PAL:  ext_sel = pal_dout;
            REGION_GFX1: ext_sel = gfx1_dout;
            REGION_GFX2: ext_sel = gfx2_dout;
            default:     ext_sel = 8'hFF;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_region <= REGION_NONE;
            ext_dout  <= 8'hFF;
        end else if (rd_stb) begin
            rd_region <= region;
            ext_dout  <= ext_sel;
        end
    end

    // RAM and I/O blocks already register their own read data
    always_comb begin
        case (rd_region)
            REGION_RAM: cpu_din = ram_dout;
            REGION_IO:  cpu_din = io_dout;
            default:    cpu_din = ext_dout;
        endcase
    end

    a_region_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_stb |=> !$isunknown(rd_region)
    );

endmodule

/* main_config.svh */
// ========================================
// Sizes and memory map of the main CPU bus
// Include wherever an address width or a
// region boundary is needed
// ========================================

`ifndef MAIN_CONFIG_SVH
`define MAIN_CONFIG_SVH

`define MAIN_RAM_AW       12
`define MAIN_ROM_AW       17

// Region boundaries, both ends inclusive
`define MAIN_IO_LO        16'h0000
`define MAIN_IO_HI        16'h001F
`define MAIN_PAL_LO       16'h0C00
`define MAIN_PAL_HI       16'h0CFF
`define MAIN_RAM_LO       16'h1000
`define MAIN_RAM_HI       16'h1FFF
`define MAIN_GFX1_LO      16'h2000
`define MAIN_GFX1_HI      16'h3FFF
`define MAIN_GFX2_LO      16'h4000
`define MAIN_GFX2_HI      16'h5FFF
`define MAIN_ROM_BANK_LO  16'h6000
`define MAIN_ROM_BANK_HI  16'h7FFF
`define MAIN_ROM_FIX_LO   16'h8000
`define MAIN_ROM_FIX_HI   16'hFFFF

`endif

/* main_decoder.sv */
// ========================================
// Main CPU address decoder
// Maps the CPU address to a bus region,
// drives the chip selects and forms the
// program ROM address. Wait is raised while
// a ROM access has no data ready yet
// ========================================

`timescale 1ns/100ps

`include "main_config.svh"

module main_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [15:0]               cpu_addr,
    input  logic                      cpu_cen,
    input  logic                      rom_ok,
    input  logic [ 3:0]               rom_bank,
    output main_pkg::bus_region_e     region,
    output logic                      rom_cs,
    output logic                      pal_cs,
    output logic                      gfx1_cs,
    output logic                      gfx2_cs,
    output logic                      ram_cs,
    output logic                      io_cs,
    output logic [`MAIN_ROM_AW-1:0]   rom_addr,
    output logic                      cpu_wait
);

    import main_pkg::*;

    // Fixed ROM sits at the top of the ROM image
    localparam logic [`MAIN_ROM_AW-16:0] ROM_FIX_PAGE = '1;

    // Each select decodes its own window of the map
    assign io_cs   = cpu_addr inside {[`MAIN_IO_LO:`MAIN_IO_HI]};
    assign pal_cs  = cpu_addr inside {[`MAIN_PAL_LO:`MAIN_PAL_HI]};
    assign ram_cs  = cpu_addr inside {[`MAIN_RAM_LO:`MAIN_RAM_HI]};
    assign gfx1_cs = cpu_addr inside {[`MAIN_GFX1_LO:`MAIN_GFX1_HI]};
    assign gfx2_cs = cpu_addr inside {[`MAIN_GFX2_LO:`MAIN_GFX2_HI]};
    assign rom_cs  = cpu_addr inside {[`MAIN_ROM_BANK_LO:`MAIN_ROM_BANK_HI],
                                      [`MAIN_ROM_FIX_LO:`MAIN_ROM_FIX_HI]};

    always_comb begin
        region = REGION_NONE;
        if (io_cs) begin
            region = REGION_IO;
        end else if (pal_cs) begin
            region = REGION_PAL;
        end else if (ram_cs) begin
            region = REGION_RAM;
        end else if (gfx1_cs) begin
            region = REGION_GFX1;
        end else if (gfx2_cs) begin
            region = REGION_GFX2;
        end else if (rom_cs) begin
            region = REGION_ROM;
        end
    end

    // Banked window is 8 kB wide and fixed window 32 kB
    always_comb begin
        if (cpu_addr inside {[`MAIN_ROM_BANK_LO:`MAIN_ROM_BANK_HI]}) begin
            rom_addr = {rom_bank, cpu_addr[12:0]};
        end else begin
            rom_addr = {ROM_FIX_PAGE, cpu_addr[14:0]};
        end
    end

    // CPU repeats the access until the ROM answers
    assign cpu_wait = cpu_cen & rom_cs & ~rom_ok;

    // Map windows must not overlap
    a_cs_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpu_cen |-> $onehot0({rom_cs, pal_cs, gfx1_cs, gfx2_cs, ram_cs, io_cs})
    );

endmodule

/* main_io_regs.sv */
// ========================================
// Main CPU I/O registers
// Cabinet inputs and DIP switches are read
// at offsets 10 to 16, latches are written
// at 18 to 1F. Also holds the CPU IRQ
// flip-flop set by the graphics interrupt
// ========================================

`timescale 1ns/100ps

module main_io_regs (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cpu_cen,
    input  logic        cpu_rnw,
    input  logic        io_cs,
    input  logic [4:0]  cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic [5:0]  joystick1,
    input  logic [5:0]  joystick2,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [3:0]  dipsw_c,
    input  logic        gfx_irqn,
    input  logic        dip_pause,
    input  logic        irq_ack,
    output logic [7:0]  io_dout,
    output logic [7:0]  snd_latch,
    output logic        snd_irq,
    output logic [3:0]  rom_bank,
    output logic [7:0]  video_bank,
    output logic        prio_latch,
    output logic        irq_n
);

    localparam logic [4:0] REG_SYSTEM = 5'h10;
    localparam logic [4:0] REG_JOY1   = 5'h11;
    localparam logic [4:0] REG_JOY2   = 5'h12;
    localparam logic [4:0] REG_DIPA   = 5'h14;
    localparam logic [4:0] REG_DIPB   = 5'h15;
    localparam logic [4:0] REG_DIPC   = 5'h16;
    localparam logic [4:0] REG_SND    = 5'h18;
    localparam logic [4:0] REG_VBANK  = 5'h1C;
    localparam logic [4:0] REG_PRIO   = 5'h1D;
    localparam logic [4:0] REG_BANK   = 5'h1F;

    logic [7:0] io_rd;
    logic       io_rd_stb;
    logic       io_wr_stb;
    logic       gfx_irqn_last;
    logic       irq_edge;

    assign io_rd_stb = cpu_cen & io_cs & cpu_rnw;
    assign io_wr_stb = cpu_cen & io_cs & ~cpu_rnw;

    // Unused upper bits of the system byte idle high
    always_comb begin
        case (cpu_addr)
            REG_SYSTEM: io_rd = {3'b111, start_button, service, coin_input};
            REG_JOY1:   io_rd = {2'b11, joystick1};
            REG_JOY2:   io_rd = {2'b11, joystick2};
            REG_DIPA:   io_rd = dipsw_a;
            REG_DIPB:   io_rd = dipsw_b;
            REG_DIPC:   io_rd = {4'hF, dipsw_c};
            default:    io_rd = 8'hFF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (io_rd_stb) begin
            io_dout <= io_rd;
        end
    end

    // Sound IRQ is a single cycle pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_latch  <= 8'd0;
            snd_irq    <= 1'b0;
            video_bank <= 8'd0;
            prio_latch <= 1'b0;
            rom_bank   <= 4'd0;
        end else begin
            snd_irq <= 1'b0;
            if (io_wr_stb) begin
                case (cpu_addr)
                    REG_SND: begin
                        snd_latch <= cpu_dout;
                        snd_irq   <= 1'b1;
                    end
                    REG_VBANK: video_bank <= cpu_dout;
                    REG_PRIO:  prio_latch <= cpu_dout[0];
                    REG_BANK:  rom_bank   <= cpu_dout[3:0];
                    default: ;
                endcase
            end
        end
    end

    // Video interrupt edge only counts while dip_pause is high
    assign irq_edge = gfx_irqn_last & ~gfx_irqn & dip_pause;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // An edge needs a high level seen after reset
            gfx_irqn_last <= 1'b0;
            irq_n         <= 1'b1;
        end else begin
            gfx_irqn_last <= gfx_irqn;
            // Acknowledge has priority over a new edge
            if (irq_ack) begin
                irq_n <= 1'b1;
            end else if (irq_edge) begin
                irq_n <= 1'b0;
            end
        end
    end

    a_snd_irq_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        snd_irq |=> !snd_irq
    );

    a_irq_from_edge: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(irq_n) |-> $past(gfx_irqn, 2) && $past(!gfx_irqn && dip_pause && !irq_ack)
    );

endmodule

/* main_pkg.sv */
// ========================================
// Types shared by the main CPU bus logic
// The decoder, the read multiplexer and the
// board top import this package
// ========================================

package main_pkg;

    // Bus region selected by the current CPU address
    // Three bits are enough for all the regions of the map
    typedef enum logic [2:0] {
        // Unmapped space, reads return FF
        REGION_NONE = 3'd0,
        // Cabinet inputs, DIP switches and write latches
        REGION_IO   = 3'd1,
        // Palette RAM inside the video block
        REGION_PAL  = 3'd2,
        // Local work RAM
        REGION_RAM  = 3'd3,
        // First graphics chip
        REGION_GFX1 = 3'd4,
        // Second graphics chip
        REGION_GFX2 = 3'd5,
        // Banked and fixed program ROM
        REGION_ROM  = 3'd6
    } bus_region_e;

endpackage

/* main_work_ram.sv */
// ========================================
// Main CPU work RAM
// Single port, 8 bit wide. Writes and reads
// happen on the bus strobe, read data is
// registered and held until the next read
// ========================================

`timescale 1ns/100ps

`include "main_config.svh"

module main_work_ram #(
    parameter int aw = `MAIN_RAM_AW
) (
    input  logic          clk,
    input  logic          cpu_cen,
    input  logic          cpu_rnw,
    input  logic          ram_cs,
    input  logic [aw-1:0] cpu_addr,
    input  logic [7:0]    cpu_dout,
    output logic [7:0]    ram_dout
);

    logic [7:0] mem [0:(2**aw)-1];
    logic       ram_wr;
    logic       ram_rd;

    assign ram_wr = cpu_cen & ram_cs & ~cpu_rnw;
    assign ram_rd = cpu_cen & ram_cs & cpu_rnw;

    always_ff @(posedge clk) begin
        if (ram_wr) begin
            mem[cpu_addr] <= cpu_dout;
        end
    end

    // Output only moves on a RAM read
    always_ff @(posedge clk) begin
        if (ram_rd) begin
            ram_dout <= mem[cpu_addr];
        end
    end

endmodule

/* sim.f */
+incdir+.
main_pkg.sv
main_decoder.sv
main_io_regs.sv
main_work_ram.sv
main_bus_mux.sv
main_board.sv
tb_main_board.sv

/* tb_main_board.sv */
// ========================================
// Testbench for the main CPU bus subsystem
// Drives the CPU bus on the falling edge,
// models ROM and video devices, and checks
// regions, latches and the interrupt path
// ========================================

`timescale 1ns/100ps

`include "main_config.svh"

module tb_main_board;

    localparam int HALF = 10;
    localparam int QUARTER = 5;
    // Many times the length of all tests together
    localparam int MAX_CYCLES = 4000;
    // Select vector order is rom, pal, gfx1, gfx2, ram, io
    localparam logic [5:0] CS_NONE = 6'b000000;
    localparam logic [5:0] CS_ROM  = 6'b100000;
    localparam logic [5:0] CS_PAL  = 6'b010000;
    localparam logic [5:0] CS_GFX1 = 6'b001000;
    localparam logic [5:0] CS_GFX2 = 6'b000100;
    localparam logic [5:0] CS_RAM  = 6'b000010;
    localparam logic [5:0] CS_IO   = 6'b000001;

    logic clk, rst_n, cpu_rnw, cpu_cen, cpu_wait, irq_ack, irq_n, rom_ok;
    logic rom_cs, pal_cs, gfx1_cs, gfx2_cs, gfx_irqn, prio_latch;
    logic service, dip_pause, snd_irq;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_dout, cpu_din, rom_data, pal_dout, gfx1_dout, gfx2_dout;
    logic [7:0]  video_bank, snd_latch, dipsw_a, dipsw_b;
    logic [5:0]  joystick1, joystick2;
    logic [3:0]  dipsw_c;
    logic [1:0]  start_button, coin_input;
    logic [`MAIN_ROM_AW-1:0] rom_addr;

    logic [5:0]  cs_seen;
    logic [16:0] rom_addr_seen;
    logic        wait_seen;
    logic [3:0]  bank_now;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [7:0]  ram_model [int];
    logic [15:0] ram_addrs [$];
    string       cur_test;
    integer      seed = 32'hd38a7ae7;
    int errors, checks, errors_at_start, tests_passed, tests_failed;
    int cycles, snd_pulses, pulses_before;

    main_board DUT (.*);

    // Device models
    assign pal_dout  = 8'h5A;
    assign gfx1_dout = 8'hA5;
    assign gfx2_dout = 8'h3C;
    assign rom_data  = rom_addr[7:0] ^ {4'h0, rom_addr[16:13]};

    initial clk = 1'b0;
    always #HALF clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (rst_n && snd_irq) begin
            snd_pulses++;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic void note_failure(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endfunction

    a_snd_irq_single: assert property (@(posedge clk) disable iff (!rst_n)
        snd_irq |=> !snd_irq) else note_failure("snd_irq lasted more than one cycle");

    a_wait_rule: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_wait == (cpu_cen && cpu_addr >= `MAIN_ROM_BANK_LO && !rom_ok))
        else note_failure("cpu_wait does not match a ROM strobe without rom_ok");

    // Expected ROM byte for a CPU address
    // Fixed page is all ones on top
    function automatic logic [7:0] rom_byte(input logic [15:0] a, input logic [3:0] bank);
        logic [3:0] page;
        page = (a < 16'h8000) ? bank : {2'b11, a[14:13]};
        return a[7:0] ^ {4'h0, page};
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        end
    endtask

    // Runs from one falling edge to the next
    task automatic bus_cycle(input logic [15:0] a, input logic rnw, input logic [7:0] d);
        cpu_addr = a;
        cpu_rnw  = rnw;
        cpu_dout = d;
        cpu_cen  = 1'b1;
        #QUARTER;
        cs_seen       = {rom_cs, pal_cs, gfx1_cs, gfx2_cs, DUT.ram_cs, DUT.io_cs};
        rom_addr_seen = rom_addr;
        wait_seen     = cpu_wait;
        @(negedge clk);
        cpu_cen = 1'b0;
        cpu_rnw = 1'b1;
    endtask

    task automatic bus_read(input logic [15:0] a, input logic [7:0] exp,
                            input logic [5:0] exp_cs);
        bus_cycle(a, 1'b1, 8'h00);
        check_value("chip select", exp_cs, cs_seen);
        check_value("cpu_din", exp, cpu_din);
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("%s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        cpu_addr = 16'h0000;
        cpu_rnw = 1'b1;
        cpu_dout = 8'h00;
        cpu_cen = 1'b0;
        irq_ack = 1'b0;
        rom_ok = 1'b1;
        gfx_irqn = 1'b1;
        dip_pause = 1'b1;
        start_button = 2'b11;
        coin_input = 2'b11;
        service = 1'b1;
        joystick1 = 6'h3F;
        joystick2 = 6'h3F;
        dipsw_a = 8'hFF;
        dipsw_b = 8'hFF;
        dipsw_c = 4'hF;
        bank_now = 4'd0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        start_test("reset");
        check_value("cpu_din", 8'hFF, cpu_din);
        check_value("irq_n", 1'b1, irq_n);
        check_value("snd_irq", 1'b0, snd_irq);
        check_value("snd_latch", 8'h00, snd_latch);
        check_value("video_bank", 8'h00, video_bank);
        check_value("prio_latch", 1'b0, prio_latch);
        end_test();

        start_test("work ram");
        repeat (64) begin
            addr = 16'h1000 | ($random(seed) & 16'h0FFF);
            data = $random(seed);
            bus_cycle(addr, 1'b0, data);
            ram_model[addr] = data;
            ram_addrs.push_back(addr);
        end
        foreach (ram_addrs[i]) begin
            bus_read(ram_addrs[i], ram_model[ram_addrs[i]], CS_RAM);
        end
        end_test();

        start_test("decode");
        bus_read(16'h0C10, 8'h5A, CS_PAL);
        bus_read(16'h2345, 8'hA5, CS_GFX1);
        bus_read(16'h4567, 8'h3C, CS_GFX2);
        bus_read(16'h0013, 8'hFF, CS_IO);
        bus_read(16'h9234, rom_byte(16'h9234, bank_now), CS_ROM);
        check_value("cpu_wait", 1'b0, wait_seen);
        bus_read(16'hE0F1, rom_byte(16'hE0F1, bank_now), CS_ROM);
        bus_read(16'h7ABC, rom_byte(16'h7ABC, bank_now), CS_ROM);
        bus_read(16'h0400, 8'hFF, CS_NONE);
        bus_read(16'h0D00, 8'hFF, CS_NONE);
        bus_read(16'h0020, 8'hFF, CS_NONE);
        rom_ok = 1'b0;
        bus_cycle(16'h8000, 1'b1, 8'h00);
        check_value("cpu_wait", 1'b1, wait_seen);
        rom_ok = 1'b1;
        end_test();

        start_test("inputs");
        repeat (4) begin
            {start_button, coin_input, service} = $random(seed);
            {joystick1, joystick2} = $random(seed);
            {dipsw_a, dipsw_b, dipsw_c} = $random(seed);
            bus_read(16'h0010, {3'b111, start_button, service, coin_input}, CS_IO);
            bus_read(16'h0011, {2'b11, joystick1}, CS_IO);
            bus_read(16'h0012, {2'b11, joystick2}, CS_IO);
            bus_read(16'h0014, dipsw_a, CS_IO);
            bus_read(16'h0015, dipsw_b, CS_IO);
            bus_read(16'h0016, {4'hF, dipsw_c}, CS_IO);
        end
        end_test();

        start_test("sound latch");
        repeat (3) begin
            data = $random(seed);
            pulses_before = snd_pulses;
            bus_cycle(16'h0018, 1'b0, data);
            check_value("snd_latch", data, snd_latch);
            check_value("snd_irq", 1'b1, snd_irq);
            @(negedge clk);
            check_value("snd_irq", 1'b0, snd_irq);
            @(negedge clk);
            check_value("snd_irq pulses", pulses_before + 1, snd_pulses);
        end
        end_test();

        start_test("banking");
        repeat (4) begin
            data = $random(seed);
            bus_cycle(16'h001F, 1'b0, data);
            bank_now = data[3:0];
            addr = 16'h6000 | ($random(seed) & 16'h1FFF);
            bus_read(addr, rom_byte(addr, bank_now), CS_ROM);
            check_value("rom_addr", {bank_now, addr[12:0]}, rom_addr_seen);
        end
        data = $random(seed);
        bus_cycle(16'h001C, 1'b0, data);
        check_value("video_bank", data, video_bank);
        bus_cycle(16'h001D, 1'b0, 8'h03);
        check_value("prio_latch", 1'b1, prio_latch);
        bus_cycle(16'h001D, 1'b0, 8'hFE);
        check_value("prio_latch", 1'b0, prio_latch);
        end_test();

        start_test("interrupt");
        gfx_irqn = 1'b0;
        @(negedge clk);
        check_value("irq_n after gated edge", 1'b0, irq_n);
        gfx_irqn = 1'b1;
        irq_ack = 1'b1;
        @(negedge clk);
        irq_ack = 1'b0;
        check_value("irq_n after ack", 1'b1, irq_n);
        dip_pause = 1'b0;
        @(negedge clk);
        gfx_irqn = 1'b0;
        repeat (4) @(negedge clk);
        check_value("irq_n while paused", 1'b1, irq_n);
        gfx_irqn = 1'b1;
        dip_pause = 1'b1;
        end_test();

        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
